// ==== src/noc_pkg.sv ====
// shared types and constants for the mesh node
// coordinates, directions, flit layout and link bundle

package noc_pkg;

    // ==============================
    // mesh constants
    // ==============================
    localparam int unsigned COORD_W   = 3;  // up to 8x8 mesh
    localparam int unsigned NUM_PORTS = 5;  // local + four neighbours

    // ==============================
    // addressing
    // ==============================
    typedef logic [COORD_W-1:0] coord_t;

    // y grows northward, x grows eastward
    typedef struct packed {
        coord_t y;
        coord_t x;
    } node_addr_t;

    // port index, also used to index every per-port array
    typedef enum logic [2:0] {
        DIR_LOCAL = 3'd0,
        DIR_NORTH = 3'd1,
        DIR_SOUTH = 3'd2,
        DIR_EAST  = 3'd3,
        DIR_WEST  = 3'd4
    } dir_e;

    // ==============================
    // payload and links
    // ==============================

    // 23 bit flit, qos on top
    typedef struct packed {
        logic       qos;        // 1 = high priority class
        logic [1:0] pkt_type;   // carried through untouched
        node_addr_t src;
        node_addr_t tgt;
        logic [7:0] data;
    } flit_t;

    // one bit per port: requests, grants, readies
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // forward half of a link, rdy travels the other way
    typedef struct packed {
        logic  vld;
        flit_t flit;
    } link_t;

endpackage

// ==== src/qos_arbiter.sv ====
// five-way arbiter for one output port
// high qos requesters win, round-robin inside a class

`timescale 1ns/1ps

module qos_arbiter (
    input  logic               clk,
    input  logic               arst_n_i,
    input  noc_pkg::port_vec_t req_i,
    input  noc_pkg::port_vec_t qos_i,
    input  logic               advance_i,   // grant is taken this cycle
    output noc_pkg::port_vec_t gnt_o
);

    import noc_pkg::*;

    localparam int unsigned PTR_W = $clog2(NUM_PORTS);

    logic [PTR_W-1:0] ptr_q;     // first candidate next time
    logic [PTR_W-1:0] win_idx;
    port_vec_t        hi_req;
    port_vec_t        cand;

    // ==============================
    // class filter
    // ==============================
    assign hi_req = req_i & qos_i;
    assign cand   = (|hi_req) ? hi_req : req_i;   // low class only if no high

    // ==============================
    // rotate from pointer
    // ==============================
    always_comb begin : pick
        int unsigned idx;
        logic        found;
        gnt_o   = '0;
        win_idx = ptr_q;
        found   = 1'b0;
        for (int unsigned off = 0; off < NUM_PORTS; off++) begin
            idx = (ptr_q + off) % NUM_PORTS;
            if (!found && cand[idx]) begin
                found      = 1'b1;
                gnt_o[idx] = 1'b1;
                win_idx    = PTR_W'(idx);
            end
        end
    end

    // pointer moves just past the winner
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (advance_i && |gnt_o) begin
            if (win_idx == PTR_W'(NUM_PORTS - 1)) begin
                ptr_q <= '0;                     // wrap
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    a_gnt_legal : assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

endmodule

// ==== src/input_port.sv ====
// one-entry input buffer of a mesh node port
// dimension-ordered XY route on the buffered target
// one-hot request toward the output ports, grant back

`timescale 1ns/1ps

module input_port #(
    parameter int unsigned   HP       = 0,                  // node x
    parameter int unsigned   VP       = 0,                  // node y
    parameter noc_pkg::dir_e PORT_DIR = noc_pkg::DIR_LOCAL
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  noc_pkg::link_t     in_link_i,
    output logic               in_rdy_o,
    output noc_pkg::port_vec_t req_o,
    input  noc_pkg::port_vec_t gnt_i,
    output noc_pkg::flit_t     flit_o
);

    import noc_pkg::*;

    localparam coord_t HERE_X = coord_t'(HP);
    localparam coord_t HERE_Y = coord_t'(VP);

    logic  full_q;      // buffer holds a flit
    flit_t buf_q;
    dir_e  route;
    logic  granted;

    // ==============================
    // buffer
    // ==============================
    assign granted  = |(gnt_i & req_o);   // leaves at the coming edge
    assign in_rdy_o = !full_q || granted; // no dependence on in vld

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (in_rdy_o) begin
            full_q <= in_link_i.vld;     // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_rdy_o && in_link_i.vld) begin
            buf_q <= in_link_i.flit;
        end
    end

    assign flit_o = buf_q;

    // ==============================
    // XY route, x first
    // ==============================
    always_comb begin
        if (buf_q.tgt.x > HERE_X) begin
            route = DIR_EAST;
        end else if (buf_q.tgt.x < HERE_X) begin
            route = DIR_WEST;
        end else if (buf_q.tgt.y > HERE_Y) begin
            route = DIR_NORTH;
        end else if (buf_q.tgt.y < HERE_Y) begin
            route = DIR_SOUTH;
        end else begin
            route = DIR_LOCAL;            // arrived
        end
    end

    always_comb begin
        req_o = '0;
        if (full_q) begin
            req_o[route] = 1'b1;
        end
    end

    // one request per buffered flit
    a_req_onehot : assert property (@(posedge clk) disable iff (!arst_n_i)
        full_q |-> $onehot(req_o));

    // XY traffic never turns back toward the neighbour it came from
    a_no_uturn : assert property (@(posedge clk) disable iff (!arst_n_i)
        (PORT_DIR == DIR_LOCAL) || !req_o[PORT_DIR]);

    // output ports only grant what was asked for
    a_gnt_live : assert property (@(posedge clk) disable iff (!arst_n_i)
        (gnt_i & ~req_o) == '0);

endmodule

// ==== src/output_port.sv ====
// output stage of one mesh node port
// qos arbiter, granted flit select, one-entry registered slice

`timescale 1ns/1ps

module output_port (
    input  logic               clk,
    input  logic               arst_n_i,
    input  noc_pkg::port_vec_t req_i,      // one bit per input port
    input  noc_pkg::flit_t     flits_i [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t gnt_o,
    output noc_pkg::link_t     out_link_o,
    input  logic               out_rdy_i
);

    import noc_pkg::*;

    logic      vld_q;
    flit_t     flit_q;
    logic      space;      // slice takes a flit at the coming edge
    port_vec_t arb_req;
    port_vec_t qos_vec;
    port_vec_t gnt;
    flit_t     sel_flit;

    // ==============================
    // arbitration
    // ==============================
    assign space   = !vld_q || out_rdy_i;
    assign arb_req = space ? req_i : '0;   // no grant without room

    always_comb begin
        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            qos_vec[i] = flits_i[i].qos;
        end
    end

    qos_arbiter u_arb (
        .clk       ( clk      ),
        .arst_n_i  ( arst_n_i ),
        .req_i     ( arb_req  ),
        .qos_i     ( qos_vec  ),
        .advance_i ( space    ),
        .gnt_o     ( gnt      )
    );

    assign gnt_o = gnt;

    // one-hot grant, so an OR of the masked flits is the select
    always_comb begin
        sel_flit = '0;
        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            if (gnt[i]) begin
                sel_flit = sel_flit | flits_i[i];
            end
        end
    end

    // ==============================
    // output slice
    // ==============================
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= 1'b0;
        end else if (space) begin
            vld_q <= |gnt;                // empties when drained with nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (space && |gnt) begin
            flit_q <= sel_flit;
        end
    end

    assign out_link_o.vld  = vld_q;
    assign out_link_o.flit = flit_q;

    // back-pressured flit stays put
    a_hold : assert property (@(posedge clk) disable iff (!arst_n_i)
        (vld_q && !out_rdy_i) |=> (vld_q && $stable(flit_q)));

endmodule

// ==== src/mesh_node.sv ====
// one node of the 8x8 mesh
// five input ports, five output ports, request/grant crossbar

`timescale 1ns/1ps

module mesh_node #(
    parameter int unsigned HP = 0,   // x position, 0..7
    parameter int unsigned VP = 0    // y position, 0..7
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  noc_pkg::link_t     in_link_i  [noc_pkg::NUM_PORTS],
    output noc_pkg::port_vec_t in_rdy_o,
    output noc_pkg::link_t     out_link_o [noc_pkg::NUM_PORTS],
    input  noc_pkg::port_vec_t out_rdy_i
);

    import noc_pkg::*;

    flit_t     flits [NUM_PORTS];   // buffered flit per input
    port_vec_t req   [NUM_PORTS];   // req[in][out]
    port_vec_t gnt   [NUM_PORTS];   // gnt[out][in]
    port_vec_t req_t [NUM_PORTS];   // req_t[out][in]
    port_vec_t gnt_t [NUM_PORTS];   // gnt_t[in][out]

    // ==============================
    // crossbar transpose
    // ==============================
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xo
        for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xi
            assign req_t[o][i] = req[i][o];
            assign gnt_t[i][o] = gnt[o][i];
        end
    end

    // ==============================
    // input ports
    // ==============================
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        input_port #(
            .HP       ( HP        ),
            .VP       ( VP        ),
            .PORT_DIR ( dir_e'(i) )
        ) u_in (
            .clk       ( clk          ),
            .arst_n_i  ( arst_n_i     ),
            .in_link_i ( in_link_i[i] ),
            .in_rdy_o  ( in_rdy_o[i]  ),
            .req_o     ( req[i]       ),
            .gnt_i     ( gnt_t[i]     ),
            .flit_o    ( flits[i]     )
        );
    end

    // ==============================
    // output ports
    // ==============================
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        output_port u_out (
            .clk        ( clk           ),
            .arst_n_i   ( arst_n_i      ),
            .req_i      ( req_t[o]      ),
            .flits_i    ( flits         ),   // every input visible to every output
            .gnt_o      ( gnt[o]        ),
            .out_link_o ( out_link_o[o] ),
            .out_rdy_i  ( out_rdy_i[o]  )
        );
    end

endmodule

// ==== verification/node_model.svh ====
// reference model of one mesh node
// XY route rule, expected queues per input/output pair, output compare

`ifndef NODE_MODEL_SVH
`define NODE_MODEL_SVH

localparam int unsigned NODE_X = 3;
localparam int unsigned NODE_Y = 4;

flit_t       exp_q   [NUM_PORTS][NUM_PORTS][$];  // [in][out], oldest first
int unsigned out_cnt [NUM_PORTS];                // matched flits per output

// x first, then y, local when both match
function automatic int unsigned xy_route(input node_addr_t tgt);
    int unsigned tx;
    int unsigned ty;
    tx = 32'(tgt.x);
    ty = 32'(tgt.y);
    if (tx > NODE_X) return DIR_EAST;
    if (tx < NODE_X) return DIR_WEST;
    if (ty > NODE_Y) return DIR_NORTH;  // y grows northward
    if (ty < NODE_Y) return DIR_SOUTH;
    return DIR_LOCAL;
endfunction

// accepted on input in_dir
task automatic expect_flit(input int unsigned in_dir, input flit_t f);
    exp_q[in_dir][xy_route(f.tgt)].push_back(f);
endtask

function automatic int unsigned pending_total();
    int unsigned sum;
    sum = 0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
        for (int unsigned o = 0; o < NUM_PORTS; o++) begin
            sum += exp_q[i][o].size();
        end
    end
    return sum;
endfunction

// an output flit must be the oldest one of some input for that output
task automatic match_output(input int unsigned o, input flit_t f);
    bit hit;
    hit = 1'b0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
        if (!hit && exp_q[i][o].size() > 0 && exp_q[i][o][0] == f) begin
            void'(exp_q[i][o].pop_front());
            hit = 1'b1;
        end
    end
    checks++;
    assert (hit) else begin
        $display("output %0d sent flit %h at %0t ns that no input queue holds at its head",
                 o, f, $time);
        errors++;
    end
    if (hit) out_cnt[o]++;
endtask

`endif

// ==== verification/mesh_node_tb.sv ====
// testbench for the mesh node with directed and random traffic
// checked against the reference model in node_model.svh

`timescale 1ns/1ps

module mesh_node_tb;

    import noc_pkg::*;

    localparam int unsigned WAIT_MAX = 200;  // cycles per wait loop

    logic      clk;
    logic      arst_n;
    link_t     in_link  [NUM_PORTS];
    port_vec_t in_rdy;
    link_t     out_link [NUM_PORTS];
    port_vec_t out_rdy;

    int unsigned errors;
    int unsigned checks;
    int unsigned hold_errs;
    int unsigned hold_seen;
    int unsigned tests_run;
    int unsigned tests_failed;
    bit          timed_out;
    logic        held_vld  [NUM_PORTS];  // back-pressured at last negedge
    flit_t       held_flit [NUM_PORTS];

    `include "node_model.svh"

    mesh_node #(
        .HP ( NODE_X ),
        .VP ( NODE_Y )
    ) UUT (
        .clk        ( clk      ),
        .arst_n_i   ( arst_n   ),
        .in_link_i  ( in_link  ),
        .in_rdy_o   ( in_rdy   ),
        .out_link_o ( out_link ),
        .out_rdy_i  ( out_rdy  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // monitor sampling at negedge
    // ==============================
    always @(negedge clk) begin
        if (arst_n) begin
            for (int unsigned i = 0; i < NUM_PORTS; i++) begin
                if (in_link[i].vld && in_rdy[i]) expect_flit(i, in_link[i].flit);
            end
            for (int unsigned o = 0; o < NUM_PORTS; o++) begin
                if (held_vld[o]) begin
                    hold_seen++;
                    checks++;
                    assert (out_link[o].vld && out_link[o].flit == held_flit[o]) else begin
                        $display("Error at %0t ns: out_link_o[%0d] got vld %b flit %h, %s %h",
                                 $time, o, out_link[o].vld, out_link[o].flit,
                                 "expected vld 1 flit", held_flit[o]);
                        errors++;
                        hold_errs++;
                    end
                end
                if (out_link[o].vld && out_rdy[o]) match_output(o, out_link[o].flit);
                held_vld[o]  = out_link[o].vld && !out_rdy[o];
                held_flit[o] = out_link[o].flit;
            end
        end
    end

    // ==============================
    // helpers
    // ==============================
    task automatic report_test(input string name, input int unsigned fails);
        tests_run++;
        if (fails != 0) tests_failed++;
        $display("test %-20s %s (%0d errors)", name, (fails == 0) ? "ok" : "FAIL", fails);
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic wait_in_fire(input int unsigned d);
        int unsigned n;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (in_link[d].vld && in_rdy[d]) break;
        end
        if (n == WAIT_MAX) note_timeout("an input handshake");
    endtask

    // cycles counts negedges since the call
    task automatic wait_out_fire(input int unsigned d, output int unsigned cycles);
        int unsigned n;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (out_link[d].vld && out_rdy[d]) break;
        end
        cycles = n + 1;
        if (n == WAIT_MAX) note_timeout("an output handshake");
    endtask

    task automatic wait_drained();
        int unsigned n;
        for (n = 0; n < WAIT_MAX; n++) begin
            @(posedge clk);              // queues only change at negedge
            if (pending_total() == 0) break;
        end
        if (n == WAIT_MAX) note_timeout("the expected queues to drain");
    endtask

    function automatic flit_t random_flit(input int unsigned in_dir);
        flit_t f;
        f.qos      = 1'($urandom);
        f.pkt_type = 2'($urandom);
        f.src      = node_addr_t'($urandom);
        f.data     = 8'($urandom);
        do begin
            f.tgt = node_addr_t'($urandom);
        end while (in_dir != DIR_LOCAL && xy_route(f.tgt) == in_dir);  // no u-turn
        return f;
    endfunction

    // ==============================
    // tests
    // ==============================
    task automatic latency_test();
        node_addr_t  tgts [NUM_PORTS];
        flit_t       f;
        int unsigned lat;
        tgts[DIR_LOCAL] = '{y: 3'd4, x: 3'd3};
        tgts[DIR_NORTH] = '{y: 3'd7, x: 3'd3};
        tgts[DIR_SOUTH] = '{y: 3'd0, x: 3'd3};
        tgts[DIR_EAST]  = '{y: 3'd4, x: 3'd6};
        tgts[DIR_WEST]  = '{y: 3'd4, x: 3'd0};
        @(posedge clk);
        out_rdy <= '1;
        for (int unsigned d = 0; d < NUM_PORTS; d++) begin
            if (!timed_out) begin
                f     = random_flit(DIR_LOCAL);
                f.tgt = tgts[d];
                @(posedge clk);
                in_link[DIR_LOCAL] <= '{vld: 1'b1, flit: f};
                wait_in_fire(DIR_LOCAL);
                @(posedge clk);
                in_link[DIR_LOCAL] <= '0;
                wait_out_fire(d, lat);
                checks += 2;
                assert (lat == 2) else begin
                    $display("Error at %0t ns: latency to out_link_o[%0d].vld got %0d expected 2",
                             $time, d, lat);
                    errors++;
                end
                assert (out_link[d].flit == f) else begin
                    $display("Error at %0t ns: out_link_o[%0d].flit got %h expected %h",
                             $time, d, out_link[d].flit, f);
                    errors++;
                end
            end
        end
    endtask

    task automatic random_traffic(input int unsigned total);
        link_t       cur   [NUM_PORTS];  // what each input drives
        bit          fired [NUM_PORTS];
        int unsigned issued;
        int unsigned sent;
        int unsigned cycles;
        issued = 0;
        sent   = 0;
        cycles = 0;
        for (int unsigned i = 0; i < NUM_PORTS; i++) cur[i] = '0;
        while (sent < total && cycles < 50 * total) begin
            @(negedge clk);
            for (int unsigned i = 0; i < NUM_PORTS; i++) begin
                fired[i] = cur[i].vld && in_rdy[i];
                if (fired[i]) sent++;
            end
            @(posedge clk);
            for (int unsigned i = 0; i < NUM_PORTS; i++) begin
                if (fired[i] || !cur[i].vld) begin   // held flit stays put
                    cur[i].vld  = (issued < total) && ($urandom_range(3) != 0);
                    cur[i].flit = random_flit(i);
                    if (cur[i].vld) issued++;
                end
                in_link[i] <= cur[i];
            end
            out_rdy <= port_vec_t'($urandom | $urandom);  // mostly ready
            cycles++;
        end
        if (sent < total) note_timeout("random traffic to be accepted");
    endtask

    task automatic qos_test();
        flit_t       fp;
        flit_t       fn;
        flit_t       fe;
        int unsigned n;
        fp     = random_flit(DIR_EAST);
        fp.tgt = '{y: 3'(NODE_Y), x: 3'(NODE_X)};
        fp.qos = 1'b0;
        fn     = random_flit(DIR_NORTH);
        fn.tgt = fp.tgt;
        fn.qos = 1'b0;
        fe     = random_flit(DIR_EAST);
        fe.tgt = fp.tgt;
        fe.qos = 1'b1;

        // a lone east flit leaves the local round-robin favouring north
        @(posedge clk);
        in_link[DIR_EAST] <= '{vld: 1'b1, flit: fp};
        wait_in_fire(DIR_EAST);
        @(posedge clk);
        in_link[DIR_EAST] <= '0;
        wait_out_fire(DIR_LOCAL, n);

        @(posedge clk);
        out_rdy[DIR_LOCAL] <= 1'b0;
        in_link[DIR_NORTH] <= '{vld: 1'b1, flit: fn};
        in_link[DIR_EAST]  <= '{vld: 1'b1, flit: fe};
        wait_in_fire(DIR_NORTH);          // both buffers empty so east goes too
        @(posedge clk);
        in_link[DIR_NORTH] <= '0;
        in_link[DIR_EAST]  <= '0;
        repeat (3) @(posedge clk);
        out_rdy[DIR_LOCAL] <= 1'b1;
        wait_out_fire(DIR_LOCAL, n);
        checks++;
        assert (out_link[DIR_LOCAL].flit == fe) else begin
            $display("Error at %0t ns: out_link_o[local].flit got %h expected %h",
                     $time, out_link[DIR_LOCAL].flit, fe);
            errors++;
        end
        wait_out_fire(DIR_LOCAL, n);
        checks++;
        assert (out_link[DIR_LOCAL].flit == fn) else begin
            $display("Error at %0t ns: out_link_o[local].flit got %h expected %h",
                     $time, out_link[DIR_LOCAL].flit, fn);
            errors++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin : main
        int unsigned mark;
        int unsigned hmark;
        int unsigned cnt0 [NUM_PORTS];
        void'($urandom(14));
        arst_n  = 1'b0;
        out_rdy = '0;
        for (int unsigned i = 0; i < NUM_PORTS; i++) begin
            in_link[i]  = '0;
            held_vld[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        mark = errors;
        checks++;
        assert (in_rdy == '1) else begin
            $display("Error at %0t ns: in_rdy_o got %b expected 11111", $time, in_rdy);
            errors++;
        end
        for (int unsigned o = 0; o < NUM_PORTS; o++) begin
            checks++;
            assert (!out_link[o].vld) else begin
                $display("Error at %0t ns: out_link_o[%0d].vld got 1 expected 0", $time, o);
                errors++;
            end
        end
        report_test("reset state", errors - mark);

        mark = errors;
        latency_test();
        report_test("isolated latency", errors - mark);

        if (!timed_out) begin
            mark  = errors;
            hmark = hold_errs;
            for (int unsigned o = 0; o < NUM_PORTS; o++) cnt0[o] = out_cnt[o];
            random_traffic(2000);
            for (int unsigned o = 0; o < NUM_PORTS; o++) begin
                checks++;
                assert (out_cnt[o] > cnt0[o]) else begin
                    $display("output %0d received no flits during random traffic", o);
                    errors++;
                end
            end
            report_test("random routing", (errors - mark) - (hold_errs - hmark));

            mark = errors;
            @(posedge clk);
            out_rdy <= '1;
            wait_drained();
            checks++;
            assert (pending_total() == 0) else begin
                $display("%0d expected flits were never delivered", pending_total());
                errors++;
            end
            report_test("order and drain", errors - mark);

            checks++;
            assert (hold_seen > 0) else begin
                $display("no output was ever held by back-pressure");
                errors++;
                hold_errs++;
            end
            report_test("back-pressure hold", hold_errs - hmark);
        end

        if (!timed_out) begin
            mark = errors;
            qos_test();
            report_test("qos priority", errors - mark);
        end

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verification
src/noc_pkg.sv
src/qos_arbiter.sv
src/input_port.sv
src/output_port.sv
src/mesh_node.sv
verification/mesh_node_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the mesh node testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module mesh_node_tb \
    -Mdir "$BUILD_DIR" -o mesh_node_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/mesh_node_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
